//--- Makefile
VERILATOR ?= verilator
TOP       := simonTb
FLIST     := flist.f
VFLAGS    := --binary --timing -Wno-fatal --top-module $(TOP)
OBJDIR    := obj_dir
LOG       := sim.log
SOURCES   := $(wildcard hw/*.sv test/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) -f $(FLIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- flist.f
+incdir+include
hw/simonPkg.sv
hw/sequenceLfsr.sv
hw/sequenceStore.sv
hw/patternPlayer.sv
hw/inputChecker.sv
hw/gameController.sv
hw/simonTop.sv
test/simonTb.sv

//--- hw/gameController.sv
// game fsm: waits for a word, runs playback, arms the checker and keeps the level
`timescale 1ns/1ps
`include "simon_macros.svh"

module gameController (
    input  logic            clock,
    input  logic            resetn,
    input  logic            go,
    input  logic            frontValid,
    input  logic            playDone,
    input  logic            stepMiss,
    input  logic            levelClear,
    output simonPkg::levelT level,
    output logic            playStart,
    output logic            checkArm,
    output logic            popWord,
    output logic            winState,
    output logic            loseState
);

    typedef enum logic [2:0] {
        stIdle,
        stWaitWord,
        stPlay,
        stInput,
        stWin,
        stLose
    } stateT;

    stateT currState;
    stateT nextState;
    logic  lastLevel;
    logic  newGame;

    assign lastLevel = (level == simonPkg::levelT'(`SIMON_LAST_LEVEL));
    // go only counts where a game can start
    assign newGame   = go & ((currState == stIdle) | (currState == stWin) |
                             (currState == stLose));

    always_comb begin
        nextState = currState;
        case (currState)
            stIdle: begin
                if (go) nextState = stWaitWord;
            end
            stWaitWord: begin
                if (frontValid) nextState = stPlay;
            end
            stPlay: begin
                if (playDone) nextState = stInput;
            end
            stInput: begin
                if (stepMiss) begin
                    nextState = stLose;
                end else if (levelClear) begin
                    nextState = lastLevel ? stWin : stWaitWord;
                end
            end
            stWin, stLose: begin
                if (go) nextState = stWaitWord;
            end
            default: nextState = stIdle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (resetn) begin
            currState <= stIdle;
        end else begin
            currState <= nextState;
        end
    end

    // level stays put on a loss so it can be read out
    always_ff @(posedge clock) begin
        if (resetn) begin
            level <= simonPkg::levelT'(1);
        end else if (newGame) begin
            level <= simonPkg::levelT'(1);
        end else if (currState == stInput && levelClear && !stepMiss && !lastLevel) begin
            level <= level + simonPkg::levelT'(1);
        end
    end

    assign playStart = (currState == stWaitWord) & frontValid;
    assign checkArm  = (currState == stInput);
    assign popWord   = (currState == stInput) & (levelClear | stepMiss); // word is spent
    assign winState  = (currState == stWin);
    assign loseState = (currState == stLose);

endmodule

//--- hw/inputChecker.sv
// key checker: takes key presses while armed and compares them with the front word in order
`timescale 1ns/1ps

module inputChecker (
    input  logic              clock,
    input  logic              resetn,
    input  logic              checkArm,
    input  simonPkg::levelT   level,
    input  simonPkg::seqWordU frontWord,
    input  logic              keyValid,
    input  simonPkg::squareT  keyCode,
    output logic              keyReady,
    output logic              stepMiss,
    output logic              levelClear
);

    logic [3:0] roundIdx;
    logic [3:0] lastIdx;
    logic       armQ;
    logic       keyTaken; // result of the last key still pending
    logic       finished; // miss or clear already reported
    logic       keyFire;

    assign lastIdx  = simonPkg::seqLength(level) - 4'd1;
    assign keyReady = checkArm & armQ & ~keyTaken & ~finished;
    assign keyFire  = keyValid & keyReady;

    always_ff @(posedge clock) begin
        if (resetn) begin
            roundIdx   <= 4'd0;
            armQ       <= 1'b0;
            keyTaken   <= 1'b0;
            finished   <= 1'b0;
            stepMiss   <= 1'b0;
            levelClear <= 1'b0;
        end else begin
            armQ       <= checkArm;
            keyTaken   <= 1'b0;
            stepMiss   <= 1'b0;
            levelClear <= 1'b0;
            if (checkArm && !armQ) begin
                roundIdx <= 4'd0; // new round
                finished <= 1'b0;
            end else if (keyFire) begin
                keyTaken <= 1'b1;
                if (keyCode != frontWord.squares[roundIdx]) begin
                    stepMiss <= 1'b1;
                    finished <= 1'b1;
                end else if (roundIdx == lastIdx) begin
                    levelClear <= 1'b1;
                    finished   <= 1'b1;
                end else begin
                    roundIdx <= roundIdx + 4'd1;
                end
            end
        end
    end

endmodule

//--- hw/patternPlayer.sv
// playback unit: flashes the first seqLength(level) squares of the front word, flash then gap
`timescale 1ns/1ps
`include "simon_macros.svh"

module patternPlayer (
    input  logic              clock,
    input  logic              resetn,
    input  logic              playStart,
    input  simonPkg::levelT   level,
    input  simonPkg::seqWordU frontWord,
    output simonPkg::squareT  square,
    output logic              flashOn,
    output logic              playDone
);

    localparam int TickBits = $clog2(`SIMON_TICK_CYCLES + 1);

    logic [TickBits-1:0] tickCount;
    logic                tickDone;
    logic [3:0]          stepIdx;
    logic [3:0]          lastStep;
    logic                gapPhase; // low while the square is lit
    logic                busy;

    assign tickDone = (tickCount == TickBits'(`SIMON_TICK_CYCLES - 1));
    assign lastStep = simonPkg::seqLength(level) - 4'd1;

    always_ff @(posedge clock) begin
        if (resetn) begin
            busy      <= 1'b0;
            gapPhase  <= 1'b0;
            stepIdx   <= 4'd0;
            tickCount <= '0;
            playDone  <= 1'b0;
        end else begin
            playDone <= 1'b0;
            if (playStart && !busy) begin
                busy      <= 1'b1;
                gapPhase  <= 1'b0;
                stepIdx   <= 4'd0;
                tickCount <= '0;
            end else if (busy) begin
                if (tickDone) begin
                    tickCount <= '0;
                    if (!gapPhase) begin
                        gapPhase <= 1'b1;
                    end else if (stepIdx == lastStep) begin
                        // last gap over
                        busy     <= 1'b0;
                        playDone <= 1'b1;
                    end else begin
                        gapPhase <= 1'b0;
                        stepIdx  <= stepIdx + 4'd1;
                    end
                end else begin
                    tickCount <= tickCount + 1'b1;
                end
            end
        end
    end

    assign flashOn = busy & ~gapPhase;
    assign square  = frontWord.squares[stepIdx];

endmodule

//--- hw/sequenceLfsr.sv
// word producer: shifts a 20-bit lfsr a full word between handshakes and offers it valid/ready
`timescale 1ns/1ps
`include "simon_macros.svh"

module sequenceLfsr (
    input  logic              clock,
    input  logic              resetn,
    output logic              seqValid,
    output simonPkg::seqWordU seqWord,
    input  logic              seqReady
);

    localparam int CountBits = $clog2(`SIMON_WORD_BITS);

    simonPkg::seqWordU    lfsrState;
    logic [CountBits-1:0] shiftCount; // shifts done toward the next word
    logic                 feedback;

    assign feedback = lfsrState.raw[`SIMON_LFSR_TAP_A-1] ^ lfsrState.raw[`SIMON_LFSR_TAP_B-1];

    always_ff @(posedge clock) begin
        if (resetn) begin
            lfsrState.raw <= `SIMON_LFSR_SEED;
            shiftCount    <= '0;
            seqValid      <= 1'b0;
        end else if (seqValid) begin
            // hold the word until the store takes it
            if (seqReady) begin
                seqValid   <= 1'b0;
                shiftCount <= '0;
            end
        end else begin
            lfsrState.raw <= {lfsrState.raw[`SIMON_WORD_BITS-2:0], feedback};
            if (shiftCount == CountBits'(`SIMON_WORD_BITS - 1)) begin
                seqValid <= 1'b1; // 20th shift lands this cycle
            end else begin
                shiftCount <= shiftCount + 1'b1;
            end
        end
    end

    assign seqWord = lfsrState;

endmodule

//--- hw/sequenceStore.sv
// two-entry word fifo between the lfsr and the player/checker, popped by the controller
`timescale 1ns/1ps

module sequenceStore (
    input  logic              clock,
    input  logic              resetn,
    input  logic              seqValid,
    input  simonPkg::seqWordU seqWord,
    output logic              seqReady,
    input  logic              popWord,
    output simonPkg::seqWordU frontWord,
    output logic              frontValid
);

    simonPkg::seqWordU entries [2];
    logic [1:0]        count;
    logic              wrPtr;
    logic              rdPtr;
    logic              push;
    logic              pop;

    assign seqReady   = (count != 2'd2);
    assign frontValid = (count != 2'd0);
    assign push       = seqValid & seqReady;
    assign pop        = popWord & frontValid;

    always_ff @(posedge clock) begin
        if (push) begin
            entries[wrPtr] <= seqWord;
        end
    end

    always_ff @(posedge clock) begin
        if (resetn) begin
            count <= 2'd0;
            wrPtr <= 1'b0;
            rdPtr <= 1'b0;
        end else begin
            if (push) wrPtr <= ~wrPtr;
            if (pop) rdPtr <= ~rdPtr;
            count <= count + {1'b0, push} - {1'b0, pop}; // both may happen together
        end
    end

    assign frontWord = entries[rdPtr];

endmodule

//--- hw/simonPkg.sv
// game types and the length rule, referenced by the RTL units through scoped names
`include "simon_macros.svh"

package simonPkg;

    typedef enum logic [1:0] {
        topLeft     = 2'd0,
        topRight    = 2'd1,
        bottomLeft  = 2'd2,
        bottomRight = 2'd3
    } squareT;

    // square i sits at bits 2i+1:2i, square 0 plays first
    typedef union packed {
        logic [`SIMON_WORD_BITS-1:0]     raw;     // lfsr view
        squareT [`SIMON_MAX_SQUARES-1:0] squares; // game view
    } seqWordU;

    typedef logic [3:0] levelT; // levels 1 to 8

    function automatic logic [3:0] seqLength(levelT level);
        return 4'(level + levelT'(`SIMON_MIN_LENGTH - 1));
    endfunction

endpackage

//--- hw/simonTop.sv
// game top level, connects the lfsr, word store, player, checker and controller
`timescale 1ns/1ps

module simonTop (
    input  logic             clock,
    input  logic             resetn,
    input  logic             go,
    input  logic             keyValid,
    input  simonPkg::squareT keyCode,
    output logic             keyReady,
    output simonPkg::squareT square,
    output logic             flashOn,
    output simonPkg::levelT  level,
    output logic             winState,
    output logic             loseState
);

    logic              seqValid;
    logic              seqReady;
    simonPkg::seqWordU seqWord;
    simonPkg::seqWordU frontWord;
    logic              frontValid;
    logic              popWord;
    logic              playStart;
    logic              playDone;
    logic              checkArm;
    logic              stepMiss;
    logic              levelClear;

    sequenceLfsr u_lfsr (
        .clock, .resetn,
        .seqValid, .seqWord, .seqReady
    );

    sequenceStore u_store (
        .clock, .resetn,
        .seqValid, .seqWord, .seqReady,
        .popWord, .frontWord, .frontValid
    );

    patternPlayer u_player (
        .clock, .resetn,
        .playStart, .level, .frontWord,
        .square, .flashOn, .playDone
    );

    inputChecker u_checker (
        .clock, .resetn,
        .checkArm, .level, .frontWord,
        .keyValid, .keyCode, .keyReady,
        .stepMiss, .levelClear
    );

    gameController u_ctrl (
        .clock, .resetn,
        .go, .frontValid, .playDone, .stepMiss, .levelClear,
        .level, .playStart, .checkArm, .popWord,
        .winState, .loseState
    );

endmodule

//--- include/simon_macros.svh
// shared sizes and constants for the memory game, included by the package and the RTL units
`ifndef SIMON_MACROS_SVH
`define SIMON_MACROS_SVH

// one sequence word holds ten 2-bit squares
`define SIMON_WORD_BITS 20
`define SIMON_MAX_SQUARES 10

// level 1 plays 3 squares, level 8 plays 10
`define SIMON_MIN_LENGTH 3
`define SIMON_LAST_LEVEL 8

// x^20 + x^17 + 1, taps counted from 1
`define SIMON_LFSR_SEED 20'h01234
`define SIMON_LFSR_TAP_A 20
`define SIMON_LFSR_TAP_B 17

`define SIMON_TICK_CYCLES 4 // clocks per flash and per gap, a board build uses ~1 s

`endif

//--- test/simonTb.sv
// testbench for simonTop, plays table-driven games against a reference lfsr model
`timescale 1ns/1ps
`include "simon_macros.svh"

module simonTb;

    localparam int NumTests    = 4;
    localparam int PlayTimeout = 400;
    localparam int KeyTimeout  = 50;
    localparam int EndTimeout  = 50;

    logic             clock = 1'b0;
    logic             resetn;
    logic             go;
    logic             keyValid;
    simonPkg::squareT keyCode;
    logic             keyReady;
    simonPkg::squareT square;
    logic             flashOn;
    simonPkg::levelT  level;
    logic             winState;
    logic             loseState;

    // scenario table, missLevel 0 means the game is won
    string testNames  [NumTests] = '{"lose_level1_step0", "lose_level3_step4",
                                     "win_with_early_key", "lose_level2_step1"};
    int    passLevels [NumTests] = '{0, 2, 8, 1};
    int    missLevel  [NumTests] = '{1, 3, 0, 2};
    int    missStep   [NumTests] = '{0, 4, -1, 1};
    bit    earlyKey   [NumTests] = '{0, 0, 1, 1};

    logic [19:0] modelState; // last word handed out by the model
    string       curTest;
    int          testErrors;
    int          testsRun;
    int          testsFailed;
    bit          aborted;

    simonTop u_dut (
        .clock, .resetn, .go, .keyValid, .keyCode, .keyReady,
        .square, .flashOn, .level, .winState, .loseState
    );

    always #4 clock = ~clock;

    task automatic tick();
        @(posedge clock);
        #1; // inputs change and outputs are read here
    endtask

    task automatic reportValue(string what, int expected, int actual);
        $display("Fail %s: %s expected %0d actual %0d", curTest, what, expected, actual);
        testErrors++;
    endtask

    task automatic reportTimeout(string what);
        $display("%s: gave up waiting for %s", curTest, what);
        aborted = 1'b1;
    endtask

    // twenty shifts of x^20 + x^17 + 1, new bit enters at bit 0
    function automatic logic [19:0] advanceWord(logic [19:0] state);
        logic [19:0] s;
        s = state;
        for (int i = 0; i < 20; i++) begin
            s = {s[18:0], s[`SIMON_LFSR_TAP_A-1] ^ s[`SIMON_LFSR_TAP_B-1]};
        end
        return s;
    endfunction

    task automatic watchPlayback(int lvl, logic [19:0] word);
        int         len;
        int         flashes;
        bit         prevFlash;
        bit         armed;
        logic [1:0] expSq;
        len       = lvl + 2;
        flashes   = 0;
        prevFlash = 1'b0;
        armed     = 1'b0;
        for (int cyc = 0; cyc < PlayTimeout; cyc++) begin
            tick();
            if (keyReady) begin
                armed = 1'b1; // checker open, playback is over
                break;
            end
            if (flashOn && !prevFlash) begin
                if (flashes < len) begin
                    expSq = word[2*flashes +: 2];
                    if (2'(square) !== expSq) begin
                        reportValue($sformatf("square %0d", flashes), int'(expSq), int'(square));
                    end
                end
                flashes++;
            end
            prevFlash = flashOn;
        end
        if (!armed) begin
            reportTimeout("the checker to take keys");
        end else if (flashes != len) begin
            reportValue("flash count", len, flashes);
        end
    endtask

    task automatic pressKey(logic [1:0] code, bit stray, logic [1:0] strayCode);
        bit ready;
        ready = 1'b0;
        for (int cyc = 0; cyc < KeyTimeout; cyc++) begin
            if (keyReady) begin
                ready = 1'b1;
                break;
            end
            tick();
        end
        if (!ready) begin
            reportTimeout("keyReady");
            return;
        end
        keyValid = 1'b1;
        keyCode  = simonPkg::squareT'(code);
        tick();
        if (stray) begin
            // checker still busy with the key just taken, this one must be ignored
            if (keyReady !== 1'b0) reportValue("keyReady after a key", 0, int'(keyReady));
            keyCode = simonPkg::squareT'(strayCode);
            tick();
        end
        keyValid = 1'b0;
    endtask

    task automatic waitLevelEnd(int lvl);
        bit seen;
        seen = 1'b0;
        for (int cyc = 0; cyc < EndTimeout; cyc++) begin
            if (winState || loseState || int'(level) != lvl) begin
                seen = 1'b1;
                break;
            end
            tick();
        end
        if (!seen) reportTimeout("the end of the level");
    endtask

    task automatic runLevel(int lvl, int badStep, bit tryEarly);
        logic [19:0] word;
        logic [1:0]  expSq;
        int          len;
        bit          expWin;
        bit          expLose;
        int          expLevel;
        word       = advanceWord(modelState);
        modelState = word;
        len        = lvl + 2;
        if (int'(level) != lvl) reportValue("level at start", lvl, int'(level));
        watchPlayback(lvl, word);
        if (aborted) return;
        for (int step = 0; step < len; step++) begin
            expSq = word[2*step +: 2];
            if (step == badStep) begin
                pressKey(expSq + 2'($urandom % 3 + 1), 1'b0, 2'd0); // any other square
                break;
            end
            // a key wrong for square 1 follows the first key while keyReady is low
            pressKey(expSq, tryEarly && step == 0, ~word[3:2]);
            if (aborted) return;
        end
        if (aborted) return;
        waitLevelEnd(lvl);
        if (aborted) return;
        expLose  = (badStep >= 0);
        expWin   = !expLose && lvl == `SIMON_LAST_LEVEL;
        expLevel = (expLose || expWin) ? lvl : lvl + 1;
        if (winState !== expWin) reportValue("winState", int'(expWin), int'(winState));
        if (loseState !== expLose) reportValue("loseState", int'(expLose), int'(loseState));
        if (int'(level) != expLevel) reportValue("level at end", expLevel, int'(level));
    endtask

    task automatic finishTest();
        testsRun++;
        if (testErrors == 0 && !aborted) begin
            $display("test %s ok", curTest);
        end else begin
            testsFailed++;
            $display("test %s failed with %0d errors", curTest, testErrors);
        end
    endtask

    initial begin
        void'($urandom(32'h69d5));
        resetn     = 1'b1;
        go         = 1'b0;
        keyValid   = 1'b0;
        keyCode    = simonPkg::topLeft;
        modelState = `SIMON_LFSR_SEED;
        aborted    = 1'b0;
        testsRun   = 0;
        testsFailed = 0;
        repeat (4) @(posedge clock);
        #1 resetn = 1'b0;

        curTest    = "reset_values";
        testErrors = 0;
        tick();
        if (flashOn !== 1'b0) reportValue("flashOn", 0, int'(flashOn));
        if (keyReady !== 1'b0) reportValue("keyReady", 0, int'(keyReady));
        if (winState !== 1'b0) reportValue("winState", 0, int'(winState));
        if (loseState !== 1'b0) reportValue("loseState", 0, int'(loseState));
        if (int'(level) != 1) reportValue("level", 1, int'(level));
        finishTest();

        for (int t = 0; t < NumTests; t++) begin
            curTest    = testNames[t];
            testErrors = 0;
            go = 1'b1;
            tick();
            go = 1'b0;
            for (int lvl = 1; lvl <= passLevels[t] && !aborted; lvl++) begin
                runLevel(lvl, -1, earlyKey[t] && lvl == 1);
            end
            if (!aborted && missLevel[t] != 0) begin
                runLevel(missLevel[t], missStep[t], 1'b0);
            end
            finishTest();
            if (aborted) break;
        end

        $display("tests run %0d, passed %0d, failed %0d",
                 testsRun, testsRun - testsFailed, testsFailed);
        if (testsFailed == 0 && !aborted) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
